// ==== spmv_top.f ====
hdl/spmv_cfg_pkg.sv
hdl/spmv_types_pkg.sv
hdl/dpram.sv
hdl/spmv_vec_lookup.sv
hdl/spmv_row_accum.sv
hdl/spmv_result_drain.sv
hdl/spmv_top.sv
dv/spmv_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the spmv testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f spmv_top.f \
	--top-module spmv_tb --Mdir obj_dir -o spmv_sim > build.log 2>&1; then
	cat build.log
	echo "build failed"
	exit 1
fi

if ! ./obj_dir/spmv_sim > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi

cat sim.log
if grep -q "TESTS PASSED" sim.log; then
	exit 0
else
	echo "pass message not found in sim.log"
	exit 1
fi

// ==== dv/spmv_tb.sv ====
`timescale 1ns/1ps

module spmv_tb;

	localparam int vec_awidth = spmv_cfg_pkg::def_vec_awidth;
	localparam int row_awidth = spmv_cfg_pkg::def_row_awidth;
	localparam int num_cols = 1 << vec_awidth;
	localparam int num_rows = 1 << row_awidth;
	localparam int rand_elems = 150;
	localparam int drain_cycles = num_rows + 8; // start, latency and gap.
	// reset, sweep, six drains, two vector loads, element phases, margin.
	localparam int timeout_cycles = 8 + num_rows + 6 * drain_cycles + num_cols
		+ num_cols / 4 + num_rows + 16 + 4 * rand_elems + 1000;

	logic clk;
	logic rst_n;
	spmv_types_pkg::vec_load_t vec_load;
	spmv_types_pkg::mat_elem_t elem;
	logic drain_start;
	logic ready;
	spmv_types_pkg::result_t result;

	logic [31:0] lcg_state;
	spmv_types_pkg::acc_t model [num_rows]; // running row sums.
	spmv_types_pkg::acc_t exp_sum [num_rows]; // frozen at drain start.
	spmv_types_pkg::vec_val_t vec_model [num_cols];
	spmv_types_pkg::acc_t exp_now;
	int unsigned cycle;
	int unsigned since_rst;
	int unsigned res_total;
	logic prev_valid;
	spmv_types_pkg::row_id_t prev_row;
	int unsigned stream_row [rand_elems];
	int unsigned stream_col [rand_elems];
	int unsigned stream_val [rand_elems];
	logic stream_gap [rand_elems];

	spmv_top #(
		.vec_awidth(vec_awidth),
		.row_awidth(row_awidth)
	) i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.vec_load(vec_load),
		.elem(elem),
		.drain_start(drain_start),
		.ready(ready),
		.result(result)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle == timeout_cycles)
			fail_run("timeout: the run did not finish within the cycle limit");
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			since_rst <= 0;
			prev_valid <= 1'b0;
		end else begin
			if (since_rst < 1000)
				since_rst <= since_rst + 1;
			prev_valid <= result.valid;
			prev_row <= result.row_id;
			if (result.valid)
				res_total <= res_total + 1;
		end
	end

	assign exp_now = exp_sum[result.row_id[row_awidth-1:0]];

	// outputs are checked mid-cycle, away from the driving edge.
	a_result_sum: assert property (@(negedge clk) disable iff (!rst_n)
		result.valid |-> result.sum == exp_now)
		else fail_run($sformatf("Error: result.sum row %h got %h expected %h",
			result.row_id, result.sum, exp_now));

	a_first_row: assert property (@(negedge clk) disable iff (!rst_n)
		(result.valid && !prev_valid) |-> result.row_id == '0)
		else fail_run($sformatf("Error: result.row_id got %h expected %h",
			result.row_id, 0));

	a_next_row: assert property (@(negedge clk) disable iff (!rst_n)
		(result.valid && prev_valid) |->
		result.row_id == spmv_types_pkg::row_id_t'(prev_row + 1'b1))
		else fail_run($sformatf("Error: result.row_id got %h expected %h",
			result.row_id, prev_row + 1'b1));

	a_ready_in_sweep: assert property (@(negedge clk) disable iff (!rst_n)
		(since_rst < num_rows) |-> !ready)
		else fail_run("ready went high before the clear sweep had finished");

	a_ready_after_sweep: assert property (@(negedge clk) disable iff (!rst_n)
		(since_rst == num_rows) |-> ready)
		else fail_run("ready did not go high when the clear sweep finished");

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw_rand(input int unsigned n, output int unsigned v);
		lcg_state = lcg_step(lcg_state);
		v = lcg_state[31:16] % n; // upper bits have the longer period.
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic idle(input int n);
		vec_load.valid = 1'b0;
		elem.valid = 1'b0;
		repeat (n) step();
	endtask

	task automatic load_vec(input int unsigned col, input int unsigned val);
		vec_load = '{valid: 1'b1, col_id: spmv_types_pkg::col_id_t'(col),
			vec_val: spmv_types_pkg::vec_val_t'(val)};
		vec_model[col] = spmv_types_pkg::vec_val_t'(val);
		step();
	endtask

	task automatic send_elem(input int unsigned row, input int unsigned col,
		input int unsigned val);
		spmv_types_pkg::acc_t prod;
		assert (ready) else fail_run("element offered while ready is low");
		prod = spmv_types_pkg::acc_t'(val) * spmv_types_pkg::acc_t'(vec_model[col]);
		model[row] = model[row] + prod;
		elem = '{valid: 1'b1, row_id: spmv_types_pkg::row_id_t'(row),
			col_id: spmv_types_pkg::col_id_t'(col),
			mat_val: spmv_types_pkg::mat_val_t'(val)};
		step();
	endtask

	task automatic drain_and_check();
		int unsigned start_cyc;
		int unsigned first_total;
		assert (ready) else fail_run("drain requested while ready is low");
		for (int r = 0; r < num_rows; r++) begin
			exp_sum[r] = model[r];
			model[r] = '0; // the drain clears every row.
		end
		first_total = res_total;
		drain_start = 1'b1;
		step();
		drain_start = 1'b0;
		start_cyc = cycle;
		assert (!ready) else fail_run("ready stayed high after drain_start");
		while (!result.valid)
			step();
		assert (cycle - start_cyc == 3) else
			fail_run($sformatf("Error: result.valid latency got %h expected %h",
				cycle - start_cyc, 3));
		while (result.valid)
			step();
		assert (res_total - first_total == num_rows) else
			fail_run($sformatf("Error: result count got %h expected %h",
				res_total - first_total, num_rows));
		assert (ready) else fail_run("ready stayed low after the last result");
	endtask

	task automatic make_stream();
		int unsigned gap;
		for (int i = 0; i < rand_elems; i++) begin
			draw_rand(num_rows, stream_row[i]);
			draw_rand(num_cols, stream_col[i]);
			draw_rand(256, stream_val[i]);
			draw_rand(4, gap);
			stream_gap[i] = (gap == 0); // about one idle cycle in four.
		end
	endtask

	task automatic play_stream();
		for (int i = 0; i < rand_elems; i++) begin
			if (stream_gap[i])
				idle(1);
			send_elem(stream_row[i], stream_col[i], stream_val[i]);
		end
		idle(4);
	endtask

	initial begin
		int unsigned c;
		int unsigned v;
		lcg_state = 32'hd3ac;
		rst_n = 1'b0;
		vec_load = '0;
		elem = '0;
		drain_start = 1'b0;
		for (int i = 0; i < num_rows; i++) begin
			model[i] = '0;
			exp_sum[i] = '0;
		end
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		while (!ready)
			step();
		drain_and_check(); // empty product.
		for (int i = 0; i < num_cols; i++) begin
			draw_rand(256, v);
			load_vec(i, v);
		end
		idle(1);
		for (int i = 0; i < num_rows; i++) begin
			draw_rand(num_cols, c);
			draw_rand(256, v);
			send_elem(i, c, v); // one nonzero per row.
		end
		idle(4);
		drain_and_check();
		for (int i = 0; i < 8; i++) begin
			draw_rand(num_cols, c);
			draw_rand(256, v);
			// three to row 3 back to back, then rows 5 and 9 interleaved.
			send_elem(i < 3 ? 3 : (i % 2 ? 5 : 9), c, v);
		end
		idle(4);
		drain_and_check();
		make_stream();
		play_stream();
		drain_and_check();
		drain_and_check(); // clear-on-read leaves zeros.
		for (int i = 0; i < num_cols; i += 4) begin
			draw_rand(256, v);
			load_vec(i, v);
		end
		idle(1);
		play_stream(); // same matrix, partly new vector.
		drain_and_check();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== hdl/spmv_top.sv ====
`timescale 1ns/1ps

module spmv_top #(
	parameter int vec_awidth = spmv_cfg_pkg::def_vec_awidth,
	parameter int row_awidth = spmv_cfg_pkg::def_row_awidth
) (
	input  logic clk,
	input  logic rst_n,
	input  spmv_types_pkg::vec_load_t vec_load,
	input  spmv_types_pkg::mat_elem_t elem,
	input  logic drain_start,
	output logic ready,
	output spmv_types_pkg::result_t result
);

	spmv_types_pkg::operand_t operand;
	spmv_types_pkg::drain_req_t drain_req;
	logic drain_busy;
	spmv_types_pkg::acc_word_t rd_sum;
	logic rd_valid;

	// input side.
	spmv_vec_lookup #(
		.vec_awidth(vec_awidth)
	) u_vec_lookup (
		.clk(clk),
		.rst_n(rst_n),
		.vec_load(vec_load),
		.elem(elem),
		.operand(operand)
	);

	// multiply and per-row sums.
	spmv_row_accum #(
		.row_awidth(row_awidth)
	) u_row_accum (
		.clk(clk),
		.rst_n(rst_n),
		.operand(operand),
		.drain_req(drain_req),
		.drain_busy(drain_busy),
		.rd_sum(rd_sum),
		.rd_valid(rd_valid),
		.ready(ready)
	);

	// output side.
	spmv_result_drain #(
		.row_awidth(row_awidth)
	) u_result_drain (
		.clk(clk),
		.rst_n(rst_n),
		.drain_start(drain_start),
		.drain_busy(drain_busy),
		.drain_req(drain_req),
		.rd_sum(rd_sum),
		.rd_valid(rd_valid),
		.result(result)
	);

endmodule

// ==== hdl/spmv_result_drain.sv ====
`timescale 1ns/1ps

module spmv_result_drain #(
	parameter int row_awidth = spmv_cfg_pkg::def_row_awidth
) (
	input  logic clk,
	input  logic rst_n,
	input  logic drain_start,
	output logic drain_busy,
	output spmv_types_pkg::drain_req_t drain_req,
	input  spmv_types_pkg::acc_word_t rd_sum,
	input  logic rd_valid,
	output spmv_types_pkg::result_t result
);

	logic issuing;
	logic [row_awidth-1:0] row_cnt;
	logic req_valid;
	spmv_types_pkg::row_id_t req_row;
	spmv_types_pkg::row_id_t row_q; // row of the sum now on rd_sum.
	logic res_valid;
	spmv_types_pkg::row_id_t res_row;
	spmv_types_pkg::acc_t res_sum;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issuing <= 1'b0;
			row_cnt <= '0;
			req_valid <= 1'b0;
			res_valid <= 1'b0;
			drain_busy <= 1'b0;
		end else begin
			req_valid <= issuing;
			res_valid <= rd_valid;
			if (drain_start) begin
				issuing <= 1'b1;
				row_cnt <= '0;
				drain_busy <= 1'b1;
			end else if (issuing) begin
				row_cnt <= row_cnt + 1'b1;
				if (row_cnt == '1)
					issuing <= 1'b0;
			end
			// busy ends on the edge that registers the last row.
			if (rd_valid && row_q == spmv_types_pkg::row_id_t'({row_awidth{1'b1}}))
				drain_busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		req_row <= spmv_types_pkg::row_id_t'(row_cnt);
		row_q <= req_row; // one edge of ram latency.
		res_row <= row_q;
		res_sum <= rd_sum.sum;
	end

	assign drain_req = '{valid: req_valid, row_id: req_row};
	assign result = '{valid: res_valid, row_id: res_row, sum: res_sum};

endmodule

// ==== hdl/spmv_row_accum.sv ====
`timescale 1ns/1ps

module spmv_row_accum #(
	parameter int row_awidth = spmv_cfg_pkg::def_row_awidth
) (
	input  logic clk,
	input  logic rst_n,
	input  spmv_types_pkg::operand_t operand,
	input  spmv_types_pkg::drain_req_t drain_req,
	input  logic drain_busy,
	output spmv_types_pkg::acc_word_t rd_sum,
	output logic rd_valid,
	output logic ready
);

	logic [row_awidth-1:0] op_row; // operand row as ram address.
	logic s2_valid; // product waiting for its write edge.
	logic [row_awidth-1:0] s2_row;
	logic [spmv_cfg_pkg::mult_bits-1:0] s2_prod;
	logic s2_fwd;
	spmv_types_pkg::acc_word_t last_sum; // forwarding register.
	spmv_types_pkg::acc_word_t base_sum;
	spmv_types_pkg::acc_word_t new_sum;
	logic [row_awidth-1:0] clr_row;
	logic sweeping;
	logic [row_awidth-1:0] sweep_cnt;
	logic wren_a;
	logic [row_awidth-1:0] addr_a;
	logic [row_awidth-1:0] addr_b;
	spmv_types_pkg::acc_word_t data_a;

	assign op_row = operand.row_id[row_awidth-1:0];

	// the previous operand wrote this row on the edge we read it.
	assign base_sum = s2_fwd ? last_sum : rd_sum;
	assign new_sum.sum = base_sum.sum + spmv_types_pkg::acc_t'(s2_prod);

	// sweep, then drain clears, then accumulation.
	assign wren_a = sweeping || rd_valid || s2_valid;
	assign addr_a = sweeping ? sweep_cnt : (rd_valid ? clr_row : s2_row);
	assign data_a = (sweeping || rd_valid) ? '0 : new_sum;
	assign addr_b = drain_busy ? drain_req.row_id[row_awidth-1:0] : op_row;

	dpram #(
		.awidth(row_awidth),
		.word_t(spmv_types_pkg::acc_word_t)
	) u_row_ram (
		.clk(clk),
		.addr_a(addr_a),
		.addr_b(addr_b),
		.wren_a(wren_a),
		.wren_b(1'b0),
		.data_a(data_a),
		.data_b('0),
		.out_a(),
		.out_b(rd_sum)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s2_valid <= 1'b0;
			rd_valid <= 1'b0;
			sweeping <= 1'b1;
			sweep_cnt <= '0;
		end else begin
			s2_valid <= operand.valid;
			rd_valid <= drain_req.valid; // also the zero write one edge later.
			if (sweeping) begin
				sweep_cnt <= sweep_cnt + 1'b1;
				if (sweep_cnt == '1)
					sweeping <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		s2_row <= op_row;
		s2_prod <= operand.mat_val * operand.vec_val;
		s2_fwd <= s2_valid && s2_row == op_row;
		clr_row <= drain_req.row_id[row_awidth-1:0];
		if (s2_valid)
			last_sum <= new_sum;
	end

	assign ready = !sweeping && !drain_busy;

	// elements were taken two edges earlier, so ready must still hold.
	a_operand_when_ready: assert property (
		@(posedge clk) disable iff (!rst_n)
		operand.valid |-> ready
	) else $error("row_accum: operand while not ready");

	a_row_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		operand.valid |-> (operand.row_id >> row_awidth) == '0
	) else $error("row_accum: row_id %0d outside row buffer", operand.row_id);

endmodule

// ==== hdl/spmv_vec_lookup.sv ====
`timescale 1ns/1ps

module spmv_vec_lookup #(
	parameter int vec_awidth = spmv_cfg_pkg::def_vec_awidth
) (
	input  logic clk,
	input  logic rst_n,
	input  spmv_types_pkg::vec_load_t vec_load,
	input  spmv_types_pkg::mat_elem_t elem,
	output spmv_types_pkg::operand_t operand
);

	spmv_types_pkg::vec_val_t vec_rd; // ram read data, one edge after elem.
	logic elem_valid_q;
	spmv_types_pkg::row_id_t elem_row_q;
	spmv_types_pkg::mat_val_t elem_val_q;
	logic op_valid;
	spmv_types_pkg::row_id_t op_row;
	spmv_types_pkg::mat_val_t op_mat_val;
	spmv_types_pkg::vec_val_t op_vec_val;

	// port a loads the vector, port b only reads.
	dpram #(
		.awidth(vec_awidth),
		.word_t(spmv_types_pkg::vec_val_t)
	) u_vec_ram (
		.clk(clk),
		.addr_a(vec_load.col_id[vec_awidth-1:0]),
		.addr_b(elem.col_id[vec_awidth-1:0]),
		.wren_a(vec_load.valid),
		.wren_b(1'b0),
		.data_a(vec_load.vec_val),
		.data_b('0),
		.out_a(),
		.out_b(vec_rd)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			elem_valid_q <= 1'b0;
			op_valid <= 1'b0;
		end else begin
			elem_valid_q <= elem.valid; // in step with the vector read.
			op_valid <= elem_valid_q;
		end
	end

	always_ff @(posedge clk) begin
		elem_row_q <= elem.row_id;
		elem_val_q <= elem.mat_val;
		op_row <= elem_row_q;
		op_mat_val <= elem_val_q;
		op_vec_val <= vec_rd; // ram output joins row and value here.
	end

	assign operand = '{valid: op_valid, row_id: op_row, mat_val: op_mat_val,
		vec_val: op_vec_val};

	a_col_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		elem.valid |-> (elem.col_id >> vec_awidth) == '0
	) else $error("vec_lookup: col_id %0d outside vector buffer", elem.col_id);

endmodule

// ==== hdl/dpram.sv ====
`timescale 1ns/1ps

module dpram #(
	parameter int awidth = 5,
	parameter type word_t = logic [7:0]
) (
	input  logic clk,
	input  logic [awidth-1:0] addr_a,
	input  logic [awidth-1:0] addr_b,
	input  logic wren_a,
	input  logic wren_b,
	input  word_t data_a,
	input  word_t data_b,
	output word_t out_a,
	output word_t out_b
);

	localparam int num_words = 1 << awidth;

	word_t ram [num_words];

	// a writing port keeps its last read data.
	// a read racing a write on the other port sees the old word.
	always_ff @(posedge clk) begin
		if (wren_a) begin
			ram[addr_a] <= data_a;
		end else begin
			out_a <= ram[addr_a];
		end
		if (wren_b) begin
			ram[addr_b] <= data_b;
		end else begin
			out_b <= ram[addr_b];
		end
	end

	// the winner of a same-address write would be tool dependent.
	a_no_write_collision: assert property (
		@(posedge clk) !(wren_a && wren_b && addr_a == addr_b)
	) else $error("dpram: both ports write address %0d", addr_a);

endmodule

// ==== hdl/spmv_types_pkg.sv ====
package spmv_types_pkg;

	typedef logic [spmv_cfg_pkg::col_id_bits-1:0] col_id_t;
	typedef logic [spmv_cfg_pkg::row_id_bits-1:0] row_id_t;
	typedef logic [spmv_cfg_pkg::mat_val_bits-1:0] mat_val_t;
	typedef logic [spmv_cfg_pkg::vec_val_bits-1:0] vec_val_t; // vector ram payload.
	typedef logic [spmv_cfg_pkg::acc_bits-1:0] acc_t;

	typedef struct packed {
		logic valid;
		col_id_t col_id;
		vec_val_t vec_val;
	} vec_load_t; // one vector buffer write.

	typedef struct packed {
		logic valid;
		row_id_t row_id;
		col_id_t col_id;
		mat_val_t mat_val;
	} mat_elem_t; // one nonzero.

	typedef struct packed {
		logic valid;
		row_id_t row_id;
		mat_val_t mat_val;
		vec_val_t vec_val;
	} operand_t; // nonzero with its vector entry.

	typedef struct packed {
		logic valid;
		row_id_t row_id;
	} drain_req_t;

	typedef struct packed {
		acc_t sum;
	} acc_word_t; // row ram payload.

	typedef struct packed {
		logic valid;
		row_id_t row_id;
		acc_t sum;
	} result_t;

endpackage

// ==== hdl/spmv_cfg_pkg.sv ====
package spmv_cfg_pkg;

	// element fields as they arrive from the caller.
	localparam int col_id_bits = 8; // column index.
	localparam int row_id_bits = 8; // row index.

	// value widths.
	localparam int mat_val_bits = 8; // matrix nonzero.
	localparam int vec_val_bits = 8; // dense vector entry.

	// a full product needs both operand widths.
	localparam int mult_bits = mat_val_bits + vec_val_bits;

	// 8 guard bits above the product, so 256 full-scale products fit in one row.
	localparam int acc_bits = 24;

	// default buffer address widths.
	localparam int def_vec_awidth = 5; // 32 vector entries.
	localparam int def_row_awidth = 4; // 16 row accumulators.

endpackage
